// File: common/axi_remap_pkg.sv
package axi_remap_pkg;

  // ID widths on the manager and subordinate sides
  localparam int unsigned ID_IN_W = 6;
  localparam int unsigned ID_OUT_W = 2;

  // one table slot per narrow ID value
  localparam int unsigned TABLE_SIZE = 2 ** ID_OUT_W;
  localparam int unsigned MAX_TXNS = 3;
  localparam int unsigned CNT_W = 2;

  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned LEN_W = 8;

  typedef logic [ID_IN_W-1:0] id_in_t;
  typedef logic [ID_OUT_W-1:0] id_out_t;
  typedef logic [1:0] resp_t;

  // address beats as seen by the manager
  typedef struct packed {
    id_in_t            id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } aw_in_t;

  typedef struct packed {
    id_in_t            id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } ar_in_t;

  // address beats as seen by the subordinate
  typedef struct packed {
    id_out_t           id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } aw_out_t;

  typedef struct packed {
    id_out_t           id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } ar_out_t;

  // write data carries no ID, so one type serves both sides
  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
    logic                last;
  } w_chan_t;

  typedef struct packed {
    id_in_t id;
    resp_t  resp;
  } b_in_t;

  typedef struct packed {
    id_out_t id;
    resp_t   resp;
  } b_out_t;

  typedef struct packed {
    id_in_t            id;
    logic [DATA_W-1:0] data;
    resp_t             resp;
    logic              last;
  } r_in_t;

  typedef struct packed {
    id_out_t           id;
    logic [DATA_W-1:0] data;
    resp_t             resp;
    logic              last;
  } r_out_t;

endpackage

// File: design/id_remap/id_remap.sv
`timescale 1ns/1ps

module id_remap (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // manager side
  input  axi_remap_pkg::aw_in_t   in_aw_i,
  input  logic                    in_aw_valid_i,
  output logic                    in_aw_ready_o,
  input  axi_remap_pkg::w_chan_t  in_w_i,
  input  logic                    in_w_valid_i,
  output logic                    in_w_ready_o,
  output axi_remap_pkg::b_in_t    in_b_o,
  output logic                    in_b_valid_o,
  input  logic                    in_b_ready_i,
  input  axi_remap_pkg::ar_in_t   in_ar_i,
  input  logic                    in_ar_valid_i,
  output logic                    in_ar_ready_o,
  output axi_remap_pkg::r_in_t    in_r_o,
  output logic                    in_r_valid_o,
  input  logic                    in_r_ready_i,

  // subordinate side
  output axi_remap_pkg::aw_out_t  out_aw_o,
  output logic                    out_aw_valid_o,
  input  logic                    out_aw_ready_i,
  output axi_remap_pkg::w_chan_t  out_w_o,
  output logic                    out_w_valid_o,
  input  logic                    out_w_ready_i,
  input  axi_remap_pkg::b_out_t   out_b_i,
  input  logic                    out_b_valid_i,
  output logic                    out_b_ready_o,
  output axi_remap_pkg::ar_out_t  out_ar_o,
  output logic                    out_ar_valid_o,
  input  logic                    out_ar_ready_i,
  input  axi_remap_pkg::r_out_t   out_r_i,
  input  logic                    out_r_valid_i,
  output logic                    out_r_ready_o
);

  logic                   wr_grant;
  axi_remap_pkg::id_out_t wr_grant_id;
  axi_remap_pkg::id_in_t  wr_orig_id;
  logic                   wr_push;
  logic                   wr_pop;

  logic                   rd_grant;
  axi_remap_pkg::id_out_t rd_grant_id;
  axi_remap_pkg::id_in_t  rd_orig_id;
  logic                   rd_push;
  logic                   rd_pop;

  // write address, held back in both directions while the table cannot grant
  assign out_aw_o.id = wr_grant_id;
  assign out_aw_o.addr = in_aw_i.addr;
  assign out_aw_o.len = in_aw_i.len;
  assign out_aw_valid_o = in_aw_valid_i & wr_grant;
  assign in_aw_ready_o = out_aw_ready_i & wr_grant;
  assign wr_push = in_aw_valid_i & in_aw_ready_o;

  // write data has no ID and goes straight through
  assign out_w_o = in_w_i;
  assign out_w_valid_o = in_w_valid_i;
  assign in_w_ready_o = out_w_ready_i;

  // every B completes one write transaction
  assign in_b_o.id = wr_orig_id;
  assign in_b_o.resp = out_b_i.resp;
  assign in_b_valid_o = out_b_valid_i;
  assign out_b_ready_o = in_b_ready_i;
  assign wr_pop = out_b_valid_i & in_b_ready_i;

  assign out_ar_o.id = rd_grant_id;
  assign out_ar_o.addr = in_ar_i.addr;
  assign out_ar_o.len = in_ar_i.len;
  assign out_ar_valid_o = in_ar_valid_i & rd_grant;
  assign in_ar_ready_o = out_ar_ready_i & rd_grant;
  assign rd_push = in_ar_valid_i & in_ar_ready_o;

  // a read burst only completes on its last beat
  assign in_r_o.id = rd_orig_id;
  assign in_r_o.data = out_r_i.data;
  assign in_r_o.resp = out_r_i.resp;
  assign in_r_o.last = out_r_i.last;
  assign in_r_valid_o = out_r_valid_i;
  assign out_r_ready_o = in_r_ready_i;
  assign rd_pop = out_r_valid_i & in_r_ready_i & out_r_i.last;

  id_remap_table i_wr_table (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_id_i   (in_aw_i.id),
    .grant_o    (wr_grant),
    .grant_id_o (wr_grant_id),
    .push_i     (wr_push),
    .rsp_id_i   (out_b_i.id),
    .orig_id_o  (wr_orig_id),
    .pop_i      (wr_pop)
  );

  id_remap_table i_rd_table (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_id_i   (in_ar_i.id),
    .grant_o    (rd_grant),
    .grant_id_o (rd_grant_id),
    .push_i     (rd_push),
    .rsp_id_i   (out_r_i.id),
    .orig_id_o  (rd_orig_id),
    .pop_i      (rd_pop)
  );

endmodule

// File: design/id_remap/id_remap_table.sv
`timescale 1ns/1ps

module id_remap_table (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // request side, driven by the address channel
  input  axi_remap_pkg::id_in_t   req_id_i,
  output logic                    grant_o,
  output axi_remap_pkg::id_out_t  grant_id_o,
  input  logic                    push_i,

  // response side, driven by the B or R channel
  input  axi_remap_pkg::id_out_t  rsp_id_i,
  output axi_remap_pkg::id_in_t   orig_id_o,
  input  logic                    pop_i
);

  // wide ID held by each slot, only meaningful while its counter is nonzero
  axi_remap_pkg::id_in_t slot_id_q [axi_remap_pkg::TABLE_SIZE];

  // outstanding transactions per slot, zero means the slot is free
  logic [axi_remap_pkg::CNT_W-1:0] slot_cnt_q [axi_remap_pkg::TABLE_SIZE];

  logic                   match_found;
  axi_remap_pkg::id_out_t match_idx;
  logic                   free_found;
  axi_remap_pkg::id_out_t free_idx;

  // search for a slot already holding the requested ID and for the lowest free slot
  always_comb begin
    match_found = 1'b0;
    match_idx = '0;
    free_found = 1'b0;
    free_idx = '0;
    for (int i = 0; i < axi_remap_pkg::TABLE_SIZE; i++) begin
      if (slot_cnt_q[i] != '0 && slot_id_q[i] == req_id_i && !match_found) begin
        match_found = 1'b1;
        match_idx = axi_remap_pkg::id_out_t'(i);
      end
      if (slot_cnt_q[i] == '0 && !free_found) begin
        free_found = 1'b1;
        free_idx = axi_remap_pkg::id_out_t'(i);
      end
    end
  end

  // an ID already in flight must keep its slot to preserve ordering, even if others are free
  always_comb begin
    if (match_found) begin
      grant_id_o = match_idx;
      grant_o = slot_cnt_q[match_idx] < axi_remap_pkg::CNT_W'(axi_remap_pkg::MAX_TXNS);
    end else begin
      grant_id_o = free_idx;
      grant_o = free_found;
    end
  end

  assign orig_id_o = slot_id_q[rsp_id_i];

  // a new owner writes its wide ID, a reused slot rewrites the same value
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      slot_id_q[grant_id_o] <= req_id_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < axi_remap_pkg::TABLE_SIZE; i++) begin
        slot_cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < axi_remap_pkg::TABLE_SIZE; i++) begin
        // push and pop on the same slot cancel out
        if (push_i && grant_id_o == axi_remap_pkg::id_out_t'(i) &&
            !(pop_i && rsp_id_i == axi_remap_pkg::id_out_t'(i))) begin
          slot_cnt_q[i] <= slot_cnt_q[i] + 1'b1;
        end else if (pop_i && rsp_id_i == axi_remap_pkg::id_out_t'(i) &&
                     !(push_i && grant_id_o == axi_remap_pkg::id_out_t'(i))) begin
          slot_cnt_q[i] <= slot_cnt_q[i] - 1'b1;
        end
      end
    end
  end

endmodule

// File: design/id_remap_ports.sv
`timescale 1ns/1ps

// flat port wrapper around the struct-based remapper core
module id_remap_ports (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  input  axi_remap_pkg::id_in_t               in_aw_id_i,
  input  logic [axi_remap_pkg::ADDR_W-1:0]    in_aw_addr_i,
  input  logic [axi_remap_pkg::LEN_W-1:0]     in_aw_len_i,
  input  logic                                in_aw_valid_i,
  output logic                                in_aw_ready_o,
  input  logic [axi_remap_pkg::DATA_W-1:0]    in_w_data_i,
  input  logic [axi_remap_pkg::DATA_W/8-1:0]  in_w_strb_i,
  input  logic                                in_w_last_i,
  input  logic                                in_w_valid_i,
  output logic                                in_w_ready_o,
  output axi_remap_pkg::id_in_t               in_b_id_o,
  output axi_remap_pkg::resp_t                in_b_resp_o,
  output logic                                in_b_valid_o,
  input  logic                                in_b_ready_i,
  input  axi_remap_pkg::id_in_t               in_ar_id_i,
  input  logic [axi_remap_pkg::ADDR_W-1:0]    in_ar_addr_i,
  input  logic [axi_remap_pkg::LEN_W-1:0]     in_ar_len_i,
  input  logic                                in_ar_valid_i,
  output logic                                in_ar_ready_o,
  output axi_remap_pkg::id_in_t               in_r_id_o,
  output logic [axi_remap_pkg::DATA_W-1:0]    in_r_data_o,
  output axi_remap_pkg::resp_t                in_r_resp_o,
  output logic                                in_r_last_o,
  output logic                                in_r_valid_o,
  input  logic                                in_r_ready_i,

  output axi_remap_pkg::id_out_t              out_aw_id_o,
  output logic [axi_remap_pkg::ADDR_W-1:0]    out_aw_addr_o,
  output logic [axi_remap_pkg::LEN_W-1:0]     out_aw_len_o,
  output logic                                out_aw_valid_o,
  input  logic                                out_aw_ready_i,
  output logic [axi_remap_pkg::DATA_W-1:0]    out_w_data_o,
  output logic [axi_remap_pkg::DATA_W/8-1:0]  out_w_strb_o,
  output logic                                out_w_last_o,
  output logic                                out_w_valid_o,
  input  logic                                out_w_ready_i,
  input  axi_remap_pkg::id_out_t              out_b_id_i,
  input  axi_remap_pkg::resp_t                out_b_resp_i,
  input  logic                                out_b_valid_i,
  output logic                                out_b_ready_o,
  output axi_remap_pkg::id_out_t              out_ar_id_o,
  output logic [axi_remap_pkg::ADDR_W-1:0]    out_ar_addr_o,
  output logic [axi_remap_pkg::LEN_W-1:0]     out_ar_len_o,
  output logic                                out_ar_valid_o,
  input  logic                                out_ar_ready_i,
  input  axi_remap_pkg::id_out_t              out_r_id_i,
  input  logic [axi_remap_pkg::DATA_W-1:0]    out_r_data_i,
  input  axi_remap_pkg::resp_t                out_r_resp_i,
  input  logic                                out_r_last_i,
  input  logic                                out_r_valid_i,
  output logic                                out_r_ready_o
);

  axi_remap_pkg::aw_in_t   in_aw;
  axi_remap_pkg::w_chan_t  in_w;
  axi_remap_pkg::b_in_t    in_b;
  axi_remap_pkg::ar_in_t   in_ar;
  axi_remap_pkg::r_in_t    in_r;

  axi_remap_pkg::aw_out_t  out_aw;
  axi_remap_pkg::w_chan_t  out_w;
  axi_remap_pkg::b_out_t   out_b;
  axi_remap_pkg::ar_out_t  out_ar;
  axi_remap_pkg::r_out_t   out_r;

  // manager side
  assign in_aw.id = in_aw_id_i;
  assign in_aw.addr = in_aw_addr_i;
  assign in_aw.len = in_aw_len_i;
  assign in_w.data = in_w_data_i;
  assign in_w.strb = in_w_strb_i;
  assign in_w.last = in_w_last_i;
  assign in_b_id_o = in_b.id;
  assign in_b_resp_o = in_b.resp;
  assign in_ar.id = in_ar_id_i;
  assign in_ar.addr = in_ar_addr_i;
  assign in_ar.len = in_ar_len_i;
  assign in_r_id_o = in_r.id;
  assign in_r_data_o = in_r.data;
  assign in_r_resp_o = in_r.resp;
  assign in_r_last_o = in_r.last;

  // subordinate side
  assign out_aw_id_o = out_aw.id;
  assign out_aw_addr_o = out_aw.addr;
  assign out_aw_len_o = out_aw.len;
  assign out_w_data_o = out_w.data;
  assign out_w_strb_o = out_w.strb;
  assign out_w_last_o = out_w.last;
  assign out_b.id = out_b_id_i;
  assign out_b.resp = out_b_resp_i;
  assign out_ar_id_o = out_ar.id;
  assign out_ar_addr_o = out_ar.addr;
  assign out_ar_len_o = out_ar.len;
  assign out_r.id = out_r_id_i;
  assign out_r.data = out_r_data_i;
  assign out_r.resp = out_r_resp_i;
  assign out_r.last = out_r_last_i;

  // valid and ready stay flat and connect to the core directly
  id_remap i_remap (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in_aw_i        (in_aw),
    .in_aw_valid_i  (in_aw_valid_i),
    .in_aw_ready_o  (in_aw_ready_o),
    .in_w_i         (in_w),
    .in_w_valid_i   (in_w_valid_i),
    .in_w_ready_o   (in_w_ready_o),
    .in_b_o         (in_b),
    .in_b_valid_o   (in_b_valid_o),
    .in_b_ready_i   (in_b_ready_i),
    .in_ar_i        (in_ar),
    .in_ar_valid_i  (in_ar_valid_i),
    .in_ar_ready_o  (in_ar_ready_o),
    .in_r_o         (in_r),
    .in_r_valid_o   (in_r_valid_o),
    .in_r_ready_i   (in_r_ready_i),
    .out_aw_o       (out_aw),
    .out_aw_valid_o (out_aw_valid_o),
    .out_aw_ready_i (out_aw_ready_i),
    .out_w_o        (out_w),
    .out_w_valid_o  (out_w_valid_o),
    .out_w_ready_i  (out_w_ready_i),
    .out_b_i        (out_b),
    .out_b_valid_i  (out_b_valid_i),
    .out_b_ready_o  (out_b_ready_o),
    .out_ar_o       (out_ar),
    .out_ar_valid_o (out_ar_valid_o),
    .out_ar_ready_i (out_ar_ready_i),
    .out_r_i        (out_r),
    .out_r_valid_i  (out_r_valid_i),
    .out_r_ready_o  (out_r_ready_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the ID remapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_id_remap -f vlog.f \
  -o tb_id_remap > build.log 2>&1 \
  && ./obj_dir/tb_id_remap > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0

// File: sim/tb_axi_slave.sv
`timescale 1ns/1ps

// subordinate model that answers queued requests in random order,
// keeping the order within each narrow id
module tb_axi_slave (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              resp_en_i,
  input  axi_remap_pkg::id_out_t            aw_id_i,
  input  logic [axi_remap_pkg::ADDR_W-1:0]  aw_addr_i,
  input  logic                              aw_valid_i,
  input  axi_remap_pkg::id_out_t            ar_id_i,
  input  logic [axi_remap_pkg::ADDR_W-1:0]  ar_addr_i,
  input  logic [axi_remap_pkg::LEN_W-1:0]   ar_len_i,
  input  logic                              ar_valid_i,
  output axi_remap_pkg::id_out_t            b_id_o,
  output axi_remap_pkg::resp_t              b_resp_o,
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  output axi_remap_pkg::id_out_t            r_id_o,
  output logic [axi_remap_pkg::DATA_W-1:0]  r_data_o,
  output axi_remap_pkg::resp_t              r_resp_o,
  output logic                              r_last_o,
  output logic                              r_valid_o,
  input  logic                              r_ready_i
);

  axi_remap_pkg::id_out_t            b_id_q [$];
  axi_remap_pkg::resp_t              b_resp_q [$];
  axi_remap_pkg::id_out_t            r_id_q [$];
  logic [axi_remap_pkg::ADDR_W-1:0]  r_addr_q [$];
  logic [axi_remap_pkg::LEN_W-1:0]   r_len_q [$];
  int b_sel;
  int r_sel;
  int r_beat;
  bit r_active;
  bit b_done;

  // move a random pick back to the oldest entry with the same id
  function automatic int oldest_of(input axi_remap_pkg::id_out_t q [$], input int pick);
    for (int j = 0; j < pick; j++) begin
      if (q[j] == q[pick]) begin
        return j;
      end
    end
    return pick;
  endfunction

  task automatic drive_r();
    r_id_o = r_id_q[r_sel];
    r_data_o = {r_addr_q[r_sel], 8'(r_beat), 6'b0, r_id_q[r_sel]};
    r_resp_o = r_addr_q[r_sel][1:0] ^ r_id_q[r_sel];
    r_last_o = (r_beat == 32'(r_len_q[r_sel]));
  endtask

  initial begin
    b_id_o = '0;
    b_resp_o = '0;
    b_valid_o = 1'b0;
    r_id_o = '0;
    r_data_o = '0;
    r_resp_o = '0;
    r_last_o = 1'b0;
    r_valid_o = 1'b0;
    r_active = 1'b0;
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_id_q.delete();
      b_resp_q.delete();
      r_id_q.delete();
      r_addr_q.delete();
      r_len_q.delete();
      r_active = 1'b0;
      #1;
      b_valid_o = 1'b0;
      r_valid_o = 1'b0;
    end else begin
      b_done = 1'b0;
      // ready is tied high, so any valid beat is accepted here
      if (aw_valid_i) begin
        b_id_q.push_back(aw_id_i);
        b_resp_q.push_back(aw_addr_i[1:0]);
      end
      if (ar_valid_i) begin
        r_id_q.push_back(ar_id_i);
        r_addr_q.push_back(ar_addr_i);
        r_len_q.push_back(ar_len_i);
      end
      if (b_valid_o && b_ready_i) begin
        b_id_q.delete(b_sel);
        b_resp_q.delete(b_sel);
        b_done = 1'b1;
      end
      if (r_valid_o && r_ready_i) begin
        if (r_last_o) begin
          r_id_q.delete(r_sel);
          r_addr_q.delete(r_sel);
          r_len_q.delete(r_sel);
          r_active = 1'b0;
        end else begin
          r_beat++;
        end
      end
      #1;
      if (b_done) begin
        b_valid_o = 1'b0;
      end
      if (!b_valid_o && resp_en_i && b_id_q.size() > 0 && $urandom % 2 == 0) begin
        b_sel = oldest_of(b_id_q, int'($urandom % b_id_q.size()));
        b_id_o = b_id_q[b_sel];
        b_resp_o = b_resp_q[b_sel];
        b_valid_o = 1'b1;
      end
      if (!r_active && resp_en_i && r_id_q.size() > 0 && $urandom % 2 == 0) begin
        r_sel = oldest_of(r_id_q, int'($urandom % r_id_q.size()));
        r_beat = 0;
        r_active = 1'b1;
      end
      if (r_active) begin
        drive_r();
      end
      r_valid_o = r_active;
    end
  end

endmodule

// File: sim/tb_id_remap.sv
`timescale 1ns/1ps

module tb_id_remap;

  localparam int NUM_TESTS = 6;
  localparam int NUM_RANDOM = 60;
  localparam int TIMEOUT_NS = NUM_TESTS * 2000;

  logic clk_i = 1'b0;
  logic rst_n = 1'b0;
  logic resp_en;

  axi_remap_pkg::id_in_t  in_aw_id, in_ar_id, in_b_id, in_r_id;
  axi_remap_pkg::id_out_t out_aw_id, out_ar_id, out_b_id, out_r_id;
  logic [15:0] in_aw_addr, in_ar_addr, out_aw_addr, out_ar_addr;
  logic [7:0]  in_aw_len, in_ar_len, out_aw_len, out_ar_len;
  logic [31:0] in_w_data, out_w_data, in_r_data, out_r_data;
  logic [3:0]  in_w_strb, out_w_strb;
  axi_remap_pkg::resp_t in_b_resp, out_b_resp, in_r_resp, out_r_resp;
  logic in_aw_valid, in_aw_ready, in_w_last, in_w_valid, in_w_ready;
  logic in_b_valid, in_b_ready, in_ar_valid, in_ar_ready;
  logic in_r_last, in_r_valid, in_r_ready;
  logic out_aw_valid, out_w_last, out_w_valid, out_b_valid, out_b_ready;
  logic out_ar_valid, out_r_last, out_r_valid, out_r_ready;

  // reference table: index 0 is write, index 1 is read
  int m_cnt [2][4];
  axi_remap_pkg::id_in_t m_id [2][4];

  int errors = 0;
  int errors_at_start = 0;
  int passed = 0;
  int failed = 0;
  bit traffic_done;
  axi_remap_pkg::id_in_t rand_ids [6] = '{6'h01, 6'h2A, 6'h15, 6'h3F, 6'h07, 6'h30};

  always #4 clk_i = ~clk_i;

  id_remap_ports dut_i (
    .clk_i(clk_i), .rst_n_i(rst_n),
    .in_aw_id_i(in_aw_id), .in_aw_addr_i(in_aw_addr), .in_aw_len_i(in_aw_len),
    .in_aw_valid_i(in_aw_valid), .in_aw_ready_o(in_aw_ready),
    .in_w_data_i(in_w_data), .in_w_strb_i(in_w_strb), .in_w_last_i(in_w_last),
    .in_w_valid_i(in_w_valid), .in_w_ready_o(in_w_ready),
    .in_b_id_o(in_b_id), .in_b_resp_o(in_b_resp), .in_b_valid_o(in_b_valid),
    .in_b_ready_i(in_b_ready),
    .in_ar_id_i(in_ar_id), .in_ar_addr_i(in_ar_addr), .in_ar_len_i(in_ar_len),
    .in_ar_valid_i(in_ar_valid), .in_ar_ready_o(in_ar_ready),
    .in_r_id_o(in_r_id), .in_r_data_o(in_r_data), .in_r_resp_o(in_r_resp),
    .in_r_last_o(in_r_last), .in_r_valid_o(in_r_valid), .in_r_ready_i(in_r_ready),
    .out_aw_id_o(out_aw_id), .out_aw_addr_o(out_aw_addr), .out_aw_len_o(out_aw_len),
    .out_aw_valid_o(out_aw_valid), .out_aw_ready_i(1'b1),
    .out_w_data_o(out_w_data), .out_w_strb_o(out_w_strb), .out_w_last_o(out_w_last),
    .out_w_valid_o(out_w_valid), .out_w_ready_i(1'b1),
    .out_b_id_i(out_b_id), .out_b_resp_i(out_b_resp), .out_b_valid_i(out_b_valid),
    .out_b_ready_o(out_b_ready),
    .out_ar_id_o(out_ar_id), .out_ar_addr_o(out_ar_addr), .out_ar_len_o(out_ar_len),
    .out_ar_valid_o(out_ar_valid), .out_ar_ready_i(1'b1),
    .out_r_id_i(out_r_id), .out_r_data_i(out_r_data), .out_r_resp_i(out_r_resp),
    .out_r_last_i(out_r_last), .out_r_valid_i(out_r_valid), .out_r_ready_o(out_r_ready)
  );

  tb_axi_slave i_slave (
    .clk_i(clk_i), .rst_n_i(rst_n), .resp_en_i(resp_en),
    .aw_id_i(out_aw_id), .aw_addr_i(out_aw_addr), .aw_valid_i(out_aw_valid),
    .ar_id_i(out_ar_id), .ar_addr_i(out_ar_addr), .ar_len_i(out_ar_len),
    .ar_valid_i(out_ar_valid),
    .b_id_o(out_b_id), .b_resp_o(out_b_resp), .b_valid_o(out_b_valid),
    .b_ready_i(out_b_ready),
    .r_id_o(out_r_id), .r_data_o(out_r_data), .r_resp_o(out_r_resp),
    .r_last_o(out_r_last), .r_valid_o(out_r_valid), .r_ready_i(out_r_ready)
  );

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp === got) else begin
      $display("Fail %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  // remap rule: reuse the slot of an outstanding id, else take the lowest free slot
  function automatic void predict(input int dir, input axi_remap_pkg::id_in_t wid,
                                  output bit grant, output int idx);
    grant = 1'b0;
    idx = 0;
    for (int i = 0; i < 4; i++) begin
      if (m_cnt[dir][i] > 0 && m_id[dir][i] == wid) begin
        grant = m_cnt[dir][i] < 3;
        idx = i;
        return;
      end
    end
    for (int i = 0; i < 4; i++) begin
      if (m_cnt[dir][i] == 0) begin
        grant = 1'b1;
        idx = i;
        return;
      end
    end
  endfunction

  function automatic int outstanding();
    int sum;
    sum = 0;
    for (int i = 0; i < 4; i++) begin
      sum += m_cnt[0][i] + m_cnt[1][i];
    end
    return sum;
  endfunction

  assert property (@(posedge clk_i) disable iff (!rst_n) out_aw_valid |-> in_aw_valid)
    else begin
      $display("out_aw_valid was raised with no write request pending");
      errors++;
    end
  assert property (@(posedge clk_i) disable iff (!rst_n) out_ar_valid |-> in_ar_valid)
    else begin
      $display("out_ar_valid was raised with no read request pending");
      errors++;
    end

  // monitor checks every beat against the reference table, then updates it
  always @(posedge clk_i) begin
    bit aw_g, ar_g;
    int aw_idx, ar_idx;
    if (rst_n) begin
      if (in_aw_valid) begin
        predict(0, in_aw_id, aw_g, aw_idx);
        check_eq("in_aw_ready", 32'(aw_g), 32'(in_aw_ready));
        check_eq("out_aw_valid", 32'(aw_g), 32'(out_aw_valid));
        if (aw_g) begin
          check_eq("out_aw_id", 32'(aw_idx), 32'(out_aw_id));
          check_eq("out_aw_addr", 32'(in_aw_addr), 32'(out_aw_addr));
          check_eq("out_aw_len", 32'(in_aw_len), 32'(out_aw_len));
        end
      end
      if (in_ar_valid) begin
        predict(1, in_ar_id, ar_g, ar_idx);
        check_eq("in_ar_ready", 32'(ar_g), 32'(in_ar_ready));
        check_eq("out_ar_valid", 32'(ar_g), 32'(out_ar_valid));
        if (ar_g) begin
          check_eq("out_ar_id", 32'(ar_idx), 32'(out_ar_id));
          check_eq("out_ar_addr", 32'(in_ar_addr), 32'(out_ar_addr));
          check_eq("out_ar_len", 32'(in_ar_len), 32'(out_ar_len));
        end
      end
      // the subordinate W ready is tied high
      check_eq("out_w_valid", 32'(in_w_valid), 32'(out_w_valid));
      check_eq("in_w_ready", 32'(1), 32'(in_w_ready));
      if (in_w_valid) begin
        check_eq("out_w_data", in_w_data, out_w_data);
        check_eq("out_w_strb", 32'(in_w_strb), 32'(out_w_strb));
        check_eq("out_w_last", 32'(in_w_last), 32'(out_w_last));
      end
      check_eq("in_b_valid", 32'(out_b_valid), 32'(in_b_valid));
      check_eq("out_b_ready", 32'(in_b_ready), 32'(out_b_ready));
      check_eq("in_r_valid", 32'(out_r_valid), 32'(in_r_valid));
      check_eq("out_r_ready", 32'(in_r_ready), 32'(out_r_ready));
      if (out_b_valid && in_b_ready) begin
        assert (m_cnt[0][out_b_id] > 0) else begin
          $display("B response arrived for a narrow id with no write outstanding");
          errors++;
        end
        check_eq("in_b_id", 32'(m_id[0][out_b_id]), 32'(in_b_id));
        check_eq("in_b_resp", 32'(out_b_resp), 32'(in_b_resp));
        m_cnt[0][out_b_id]--;
      end
      if (out_r_valid && in_r_ready) begin
        assert (m_cnt[1][out_r_id] > 0) else begin
          $display("R beat arrived for a narrow id with no read outstanding");
          errors++;
        end
        check_eq("in_r_id", 32'(m_id[1][out_r_id]), 32'(in_r_id));
        check_eq("in_r_data", out_r_data, in_r_data);
        check_eq("in_r_resp", 32'(out_r_resp), 32'(in_r_resp));
        check_eq("in_r_last", 32'(out_r_last), 32'(in_r_last));
        if (out_r_last) begin
          m_cnt[1][out_r_id]--;
        end
      end
      if (in_aw_valid && aw_g) begin
        m_id[0][aw_idx] = in_aw_id;
        m_cnt[0][aw_idx]++;
      end
      if (in_ar_valid && ar_g) begin
        m_id[1][ar_idx] = in_ar_id;
        m_cnt[1][ar_idx]++;
      end
    end
  end

  task automatic send_aw(input axi_remap_pkg::id_in_t id, input logic [15:0] addr,
                         input logic [7:0] len);
    in_aw_id = id;
    in_aw_addr = addr;
    in_aw_len = len;
    in_aw_valid = 1'b1;
    do begin
      @(posedge clk_i);
    end while (in_aw_ready !== 1'b1);
    #1;
    in_aw_valid = 1'b0;
  endtask

  task automatic send_w(input int beats);
    for (int i = 0; i < beats; i++) begin
      in_w_data = $urandom;
      in_w_strb = 4'($urandom);
      in_w_last = (i == beats - 1);
      in_w_valid = 1'b1;
      do begin
        @(posedge clk_i);
      end while (in_w_ready !== 1'b1);
      #1;
    end
    in_w_valid = 1'b0;
  endtask

  task automatic send_ar(input axi_remap_pkg::id_in_t id, input logic [15:0] addr,
                         input logic [7:0] len);
    in_ar_id = id;
    in_ar_addr = addr;
    in_ar_len = len;
    in_ar_valid = 1'b1;
    do begin
      @(posedge clk_i);
    end while (in_ar_ready !== 1'b1);
    #1;
    in_ar_valid = 1'b0;
  endtask

  task automatic write(input axi_remap_pkg::id_in_t id, input logic [15:0] addr,
                       input logic [7:0] len);
    send_aw(id, addr, len);
    send_w(int'(len) + 1);
  endtask

  // let the subordinate answer until the reference table is empty
  task automatic drain();
    resp_en = 1'b1;
    do begin
      @(posedge clk_i);
      #1;
    end while (outstanding() != 0);
    resp_en = 1'b0;
  endtask

  // release responses a few cycles after a stalled request started
  task automatic release_later();
    repeat (4) @(posedge clk_i);
    #1;
    resp_en = 1'b1;
  endtask

  // random back-pressure on B and R while the mixed traffic runs
  task automatic toggle_ready();
    while (!traffic_done) begin
      @(posedge clk_i);
      #1;
      in_b_ready = 1'($urandom);
      in_r_ready = 1'($urandom);
    end
    in_b_ready = 1'b1;
    in_r_ready = 1'b1;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      passed++;
      $display("test %s: pass", name);
    end else begin
      failed++;
      $display("test %s: fail with %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the tests completed");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h0261a291));
    resp_en = 1'b0;
    traffic_done = 1'b0;
    {in_aw_id, in_aw_addr, in_aw_len, in_aw_valid} = '0;
    {in_ar_id, in_ar_addr, in_ar_len, in_ar_valid} = '0;
    {in_w_data, in_w_strb, in_w_last, in_w_valid} = '0;
    in_b_ready = 1'b1;
    in_r_ready = 1'b1;
    for (int d = 0; d < 2; d++) begin
      for (int i = 0; i < 4; i++) begin
        m_cnt[d][i] = 0;
        m_id[d][i] = '0;
      end
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_n = 1'b1;

    write(6'h2A, 16'h1234, 8'd1);
    drain();
    end_test("single_write");

    write(6'h05, 16'h0100, 8'd0);
    write(6'h06, 16'h0200, 8'd0);
    write(6'h05, 16'h0300, 8'd0);
    drain();
    end_test("same_id_reused");

    for (int i = 1; i <= 4; i++) begin
      write(6'(i), 16'(i * 16), 8'd0);
    end
    fork
      send_aw(6'h05, 16'h0500, 8'd0);
      release_later();
    join
    send_w(1);
    drain();
    end_test("table_full");

    for (int i = 0; i < 3; i++) begin
      send_ar(6'h11, 16'(i * 4), 8'd0);
    end
    fork
      send_ar(6'h11, 16'h0040, 8'd0);
      release_later();
    join
    drain();
    end_test("counter_limit");

    send_ar(6'h20, 16'h0800, 8'd3);
    send_ar(6'h21, 16'h0810, 8'd0);
    send_ar(6'h22, 16'h0820, 8'd0);
    send_ar(6'h23, 16'h0830, 8'd0);
    fork
      send_ar(6'h24, 16'h0840, 8'd0);
      release_later();
    join
    drain();
    end_test("read_bursts");

    resp_en = 1'b1;
    fork
      begin
        for (int n = 0; n < NUM_RANDOM; n++) begin
          if ($urandom % 2 == 0) begin
            write(rand_ids[$urandom % 6], 16'($urandom), 8'($urandom % 4));
          end else begin
            send_ar(rand_ids[$urandom % 6], 16'($urandom), 8'($urandom % 4));
          end
        end
        traffic_done = 1'b1;
      end
      toggle_ready();
    join
    drain();
    end_test("random_traffic");

    $display("tests passed %0d, tests failed %0d", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
common/axi_remap_pkg.sv
design/id_remap/id_remap_table.sv
design/id_remap/id_remap.sv
design/id_remap_ports.sv
sim/tb_axi_slave.sv
sim/tb_id_remap.sv
